// ==== include/soc_config.svh ====
// ----------------------------------------
// Address map and width settings for the MMIO block
// Include wherever a region code or data width is needed
// ----------------------------------------
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Host word address and region field inside it
`define SOC_ADDR_WIDTH 24
`define SOC_REGION_LSB 16
`define SOC_REGION_WIDTH 4

// Region codes
`define SOC_REGION_STATUS 0
`define SOC_REGION_DSP 1
`define SOC_REGION_PAD 2
`define SOC_REGION_FLASH 3

// Peripheral data widths
`define SOC_DSP_OPERAND_WIDTH 16
`define SOC_LED_WIDTH 8

`endif

// ==== hw/soc_pkg.sv ====
// ----------------------------------------
// Shared bus, region and flash pin types
// Imported by the RTL and the testbench
// ----------------------------------------
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

    // One bus data word
    typedef logic [31:0] word_t;

    // Host word address
    typedef logic [`SOC_ADDR_WIDTH-1:0] addr_t;

    // Decoded target of a host access
    typedef enum logic [2:0] {
        REGION_STATUS = `SOC_REGION_STATUS,
        REGION_DSP = `SOC_REGION_DSP,
        REGION_PAD = `SOC_REGION_PAD,
        REGION_FLASH = `SOC_REGION_FLASH,
        REGION_UNMAPPED = 4
    } region_e;

    // Flash bit-bang register
    // Write data bits 15, 9, 8, 7:4 and 3:0 in field order
    typedef struct packed {
        logic active;
        logic csn;
        logic clk;
        logic [3:0] in_en;
        logic [3:0] in;
    } flash_pins_t;

    typedef logic [`SOC_LED_WIDTH-1:0] led_t;

endpackage

`default_nettype wire

// ==== hw/mmio_if.sv ====
// ----------------------------------------
// One decoded peripheral access and its read data
// mmio_bus drives the bus side, each peripheral the periph side
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface mmio_if import soc_pkg::*; ();

    // Single cycle access strobe
    logic sel;
    logic we;
    // Bit 0 is word address bit 0, bit 1 picks pad over status
    logic [1:0] offset;
    word_t write_data;
    // Combinational, valid while sel is high
    word_t read_data;

    modport bus (output sel, we, offset, write_data, input read_data);

    modport periph (input sel, we, offset, write_data, output read_data);

endinterface

`default_nettype wire

// ==== hw/mmio_bus.sv ====
// ----------------------------------------
// Host four-phase req/ack handshake and address decoder
// Pulses one peripheral select per access, then returns read data
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module mmio_bus import soc_pkg::*; (
    input logic vdp_clk,
    input logic vdp_reset,

    input logic host_req,
    input logic host_we,
    input addr_t host_address,
    input word_t host_write_data,
    output logic host_ack,
    output word_t host_read_data,

    mmio_if.bus io_bus,
    mmio_if.bus dsp_bus,
    mmio_if.bus flash_bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SELECT,
        ST_ACK
    } state_e;

    state_e state;
    region_e region;
    region_e region_q;
    word_t selected_read_data;
    logic [1:0] offset;

    function automatic region_e decode_region(input addr_t address);
        logic [`SOC_REGION_WIDTH-1:0] code;
        code = address[`SOC_REGION_LSB +: `SOC_REGION_WIDTH];
        case (code)
            `SOC_REGION_STATUS: decode_region = REGION_STATUS;
            `SOC_REGION_DSP: decode_region = REGION_DSP;
            `SOC_REGION_PAD: decode_region = REGION_PAD;
            `SOC_REGION_FLASH: decode_region = REGION_FLASH;
            default: decode_region = REGION_UNMAPPED;
        endcase
    endfunction

    assign region = decode_region(host_address);

    // Idle -> select for one cycle -> ack until req drops
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (host_req) state <= ST_SELECT;
                ST_SELECT: state <= ST_ACK;
                ST_ACK: if (!host_req) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (state == ST_IDLE && host_req) begin
            region_q <= region;
        end
    end

    assign host_ack = (state == ST_ACK);

    // Host holds address and data stable while req is high
    // Bit 1 of the region code tells pad from status
    assign offset = {host_address[`SOC_REGION_LSB + 1], host_address[0]};

    assign io_bus.sel = (state == ST_SELECT) &&
                        (region_q == REGION_STATUS || region_q == REGION_PAD);
    assign dsp_bus.sel = (state == ST_SELECT) && (region_q == REGION_DSP);
    assign flash_bus.sel = (state == ST_SELECT) && (region_q == REGION_FLASH);

    assign io_bus.we = host_we;
    assign dsp_bus.we = host_we;
    assign flash_bus.we = host_we;

    assign io_bus.offset = offset;
    assign dsp_bus.offset = offset;
    assign flash_bus.offset = offset;

    assign io_bus.write_data = host_write_data;
    assign dsp_bus.write_data = host_write_data;
    assign flash_bus.write_data = host_write_data;

    // Unmapped accesses read back zero
    always_comb begin
        case (region_q)
            REGION_STATUS, REGION_PAD: selected_read_data = io_bus.read_data;
            REGION_DSP: selected_read_data = dsp_bus.read_data;
            REGION_FLASH: selected_read_data = flash_bus.read_data;
            default: selected_read_data = '0;
        endcase
    end

    // Captured on the edge that ends the select cycle, as ack rises
    always_ff @(posedge vdp_clk) begin
        if (state == ST_SELECT) begin
            host_read_data <= selected_read_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/io_ports.sv ====
// ----------------------------------------
// Status LEDs and gamepad control
// Serves both the status and pad regions through one bus
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module io_ports import soc_pkg::*; (
    input logic vdp_clk,
    input logic vdp_reset,

    mmio_if.periph bus,

    output led_t led,
    output logic pad_latch,
    output logic pad_clk,
    input logic [1:0] pad_data
);

    led_t led_q;
    // Bit 0 latch, bit 1 clock
    logic [1:0] pad_ctrl;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            led_q <= '0;
            pad_ctrl <= 2'b00;
        end else if (bus.sel && bus.we) begin
            if (bus.offset[1]) begin
                pad_ctrl <= bus.write_data[1:0];
            end else begin
                led_q <= bus.write_data[`SOC_LED_WIDTH-1:0];
            end
        end
    end

    assign led = led_q;
    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];

    // Pad pins read back raw
    assign bus.read_data = bus.offset[1] ? word_t'(pad_data) : word_t'(led_q);

endmodule

`default_nettype wire

// ==== hw/dsp_multiplier.sv ====
// ----------------------------------------
// Signed 16x16 multiplier peripheral
// Offset 0 loads operand a, offset 1 operand b, reads give the product
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module dsp_multiplier import soc_pkg::*; (
    input logic vdp_clk,

    mmio_if.periph bus
);

    localparam int W = `SOC_DSP_OPERAND_WIDTH;

    logic signed [W-1:0] operand_a;
    logic signed [W-1:0] operand_b;
    logic signed [2*W-1:0] product_q;

    // Operand writes by offset
    always_ff @(posedge vdp_clk) begin
        if (bus.sel && bus.we && !bus.offset[0]) begin
            operand_a <= bus.write_data[W-1:0];
        end

        if (bus.sel && bus.we && bus.offset[0]) begin
            operand_b <= bus.write_data[W-1:0];
        end

        // Product lags an operand write by one edge
        product_q <= operand_a * operand_b;
    end

    assign bus.read_data = word_t'(product_q);

endmodule

`default_nettype wire

// ==== hw/flash_ctrl.sv ====
// ----------------------------------------
// Flash bit-bang control register
// Drives the flash pins while active, idle pins otherwise
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module flash_ctrl import soc_pkg::*; (
    input logic vdp_clk,
    input logic vdp_reset,

    mmio_if.periph bus,

    output logic flash_clk,
    output logic flash_csn,
    output logic [3:0] flash_in,
    output logic [3:0] flash_in_en,
    input logic [3:0] flash_out
);

    flash_pins_t pins_q;
    flash_pins_t write_pins;

    assign write_pins = '{
        active: bus.write_data[15],
        csn: bus.write_data[9],
        clk: bus.write_data[8],
        in_en: bus.write_data[7:4],
        in: bus.write_data[3:0]
    };

    // Bit-bang register written whole by any write
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pins_q.active <= 1'b0;
            pins_q.clk <= 1'b0;
            pins_q.in_en <= 4'b0000;
        end else if (bus.sel && bus.we) begin
            pins_q <= write_pins;
        end
    end

    always_comb begin
        if (pins_q.active) begin
            flash_csn = pins_q.csn;
            flash_clk = pins_q.clk;
            flash_in_en = pins_q.in_en;
            flash_in = pins_q.in;
        end else begin
            // Idle: deselected, clock low, outputs released
            flash_csn = 1'b1;
            flash_clk = 1'b0;
            flash_in_en = 4'b0000;
            flash_in = 4'b0000;
        end
    end

    assign bus.read_data = word_t'(flash_out);

endmodule

`default_nettype wire

// ==== hw/soc_mmio_top.sv ====
// ----------------------------------------
// Top level of the MMIO peripheral block
// Host handshake port in, LED, gamepad and flash pins out
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module soc_mmio_top import soc_pkg::*; (
    input logic vdp_clk,
    input logic vdp_reset,

    input logic host_req,
    input logic host_we,
    input addr_t host_address,
    input word_t host_write_data,
    output logic host_ack,
    output word_t host_read_data,

    output led_t led,
    output logic pad_latch,
    output logic pad_clk,
    input logic [1:0] pad_data,

    output logic flash_clk,
    output logic flash_csn,
    output logic [3:0] flash_in,
    output logic [3:0] flash_in_en,
    input logic [3:0] flash_out
);

    mmio_if io_bus();
    mmio_if dsp_bus();
    mmio_if flash_bus();

    mmio_bus mmio_bus_i (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .host_req(host_req),
        .host_we(host_we),
        .host_address(host_address),
        .host_write_data(host_write_data),
        .host_ack(host_ack),
        .host_read_data(host_read_data),
        .io_bus(io_bus.bus),
        .dsp_bus(dsp_bus.bus),
        .flash_bus(flash_bus.bus)
    );

    io_ports io_ports_i (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(io_bus.periph),
        .led(led),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .pad_data(pad_data)
    );

    dsp_multiplier dsp_multiplier_i (
        .vdp_clk(vdp_clk),
        .bus(dsp_bus.periph)
    );

    flash_ctrl flash_ctrl_i (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(flash_bus.periph),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_in(flash_in),
        .flash_in_en(flash_in_en),
        .flash_out(flash_out)
    );

endmodule

`default_nettype wire

// ==== testbench/soc_mmio_properties.sv ====
// ----------------------------------------
// Handshake, select and flash pin assertions
// Bound into mmio_bus and flash_ctrl below
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module soc_mmio_properties (
    input logic vdp_clk,
    input logic vdp_reset,
    input logic host_req,
    input logic host_ack,
    input logic [2:0] sel,
    input logic active,
    input logic csn
);

    // Ack holds until the host drops req
    ack_holds: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        host_req && host_ack |=> host_ack)
        else $error("ack fell while req was still high");

    sel_onehot: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $onehot0(sel))
        else $error("more than one peripheral select high");

    sel_pulse: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        |sel |=> !(|sel))
        else $error("peripheral select high for more than one cycle");

    // Idle flash pins keep the part deselected
    csn_idle: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        !active |-> csn)
        else $error("flash csn low while bit-bang control is inactive");

endmodule

bind mmio_bus soc_mmio_properties bus_props_i (
    .vdp_clk(vdp_clk),
    .vdp_reset(vdp_reset),
    .host_req(host_req),
    .host_ack(host_ack),
    .sel({io_bus.sel, dsp_bus.sel, flash_bus.sel}),
    .active(1'b1),
    .csn(1'b1)
);

bind flash_ctrl soc_mmio_properties pin_props_i (
    .vdp_clk(vdp_clk),
    .vdp_reset(vdp_reset),
    .host_req(1'b0),
    .host_ack(1'b0),
    .sel(3'b000),
    .active(pins_q.active),
    .csn(flash_csn)
);

`default_nettype wire

// ==== testbench/soc_mmio_tb.sv ====
// ----------------------------------------
// Testbench for the MMIO peripheral block
// Applies a stimulus table through the host handshake
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module soc_mmio_tb import soc_pkg::*; ();

    localparam int NUM_STEPS = 16;
    localparam int TIMEOUT_CYCLES = NUM_STEPS * 10 + 20;
    localparam addr_t STATUS_ADDR = addr_t'(`SOC_REGION_STATUS << `SOC_REGION_LSB);
    localparam addr_t DSP_A_ADDR = addr_t'(`SOC_REGION_DSP << `SOC_REGION_LSB);
    localparam addr_t DSP_B_ADDR = addr_t'((`SOC_REGION_DSP << `SOC_REGION_LSB) + 1);
    localparam addr_t PAD_ADDR = addr_t'(`SOC_REGION_PAD << `SOC_REGION_LSB);
    localparam addr_t FLASH_ADDR = addr_t'(`SOC_REGION_FLASH << `SOC_REGION_LSB);
    // Region code 0xa has no peripheral
    localparam addr_t UNMAPPED_ADDR = addr_t'(32'ha << `SOC_REGION_LSB);
    // Differs from the last pad control write
    localparam logic [1:0] PAD_VALUE = 2'b01;
    localparam logic [3:0] FLASH_VALUE = 4'ha;
    // Expected pin images with the active field held at 0
    localparam flash_pins_t FLASH_IDLE = flash_pins_t'(11'b0_1_0_0000_0000);
    localparam flash_pins_t FLASH_DRIVEN = flash_pins_t'(11'b0_0_1_1100_0101);

    typedef struct {
        logic we;
        addr_t address;
        word_t write_data;
        word_t exp_read;
        led_t exp_led;
        logic [1:0] exp_pad;
        flash_pins_t exp_flash;
    } step_t;

    logic vdp_clk = 1'b0;
    logic vdp_reset;
    logic host_req;
    logic host_we;
    addr_t host_address;
    word_t host_write_data;
    logic host_ack;
    word_t host_read_data;
    led_t led;
    logic pad_latch;
    logic pad_clk;
    logic [1:0] pad_data;
    logic flash_clk;
    logic flash_csn;
    logic [3:0] flash_in;
    logic [3:0] flash_in_en;
    logic [3:0] flash_out;

    step_t steps [NUM_STEPS];
    int num_built = 0;
    int cycle_count = 0;

    soc_mmio_top dut_i (.*);

    always #20 vdp_clk = ~vdp_clk;

    always @(posedge vdp_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run("timeout: the run went past its cycle limit");
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_led(input string name, input led_t got, input led_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_flash(input string name, input flash_pins_t got,
                               input flash_pins_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
                $time, name, got, exp));
        end
    endtask

    task automatic add_step(input logic we, input addr_t address, input word_t write_data,
                            input word_t exp_read, input led_t exp_led,
                            input logic [1:0] exp_pad, input flash_pins_t exp_flash);
        steps[num_built] = '{we, address, write_data, exp_read, exp_led, exp_pad, exp_flash};
        num_built++;
    endtask

    task automatic build_table();
        logic signed [15:0] op_a;
        logic signed [15:0] op_b;
        logic signed [15:0] op_c;
        // a and c negative, b positive
        op_a = 16'($urandom) | 16'h8000;
        op_b = 16'($urandom) & 16'h7fff;
        op_c = 16'($urandom) | 16'h8000;
        add_step(1'b0, STATUS_ADDR, '0, '0, 8'h00, 2'b00, FLASH_IDLE);
        add_step(1'b0, UNMAPPED_ADDR, '0, '0, 8'h00, 2'b00, FLASH_IDLE);
        add_step(1'b1, STATUS_ADDR, 32'h1234_56a5, '0, 8'ha5, 2'b00, FLASH_IDLE);
        add_step(1'b0, STATUS_ADDR, '0, 32'h0000_00a5, 8'ha5, 2'b00, FLASH_IDLE);
        add_step(1'b1, PAD_ADDR, 32'hffff_fffd, '0, 8'ha5, 2'b01, FLASH_IDLE);
        add_step(1'b1, PAD_ADDR, 32'h0000_0002, '0, 8'ha5, 2'b10, FLASH_IDLE);
        add_step(1'b0, PAD_ADDR, '0, word_t'(PAD_VALUE), 8'ha5, 2'b10, FLASH_IDLE);
        add_step(1'b1, DSP_A_ADDR, {16'($urandom), op_a}, '0, 8'ha5, 2'b10, FLASH_IDLE);
        add_step(1'b1, DSP_B_ADDR, {16'($urandom), op_b}, '0, 8'ha5, 2'b10, FLASH_IDLE);
        add_step(1'b0, DSP_A_ADDR, '0, word_t'(int'(op_a) * int'(op_b)), 8'ha5, 2'b10,
                 FLASH_IDLE);
        add_step(1'b1, DSP_B_ADDR, {16'($urandom), op_c}, '0, 8'ha5, 2'b10, FLASH_IDLE);
        add_step(1'b0, DSP_B_ADDR, '0, word_t'(int'(op_a) * int'(op_c)), 8'ha5, 2'b10,
                 FLASH_IDLE);
        // Active, csn low, clk high, in_en c, in 5
        add_step(1'b1, FLASH_ADDR, 32'h0000_81c5, '0, 8'ha5, 2'b10, FLASH_DRIVEN);
        add_step(1'b0, FLASH_ADDR, '0, word_t'(FLASH_VALUE), 8'ha5, 2'b10, FLASH_DRIVEN);
        add_step(1'b1, FLASH_ADDR, 32'hffff_7fff, '0, 8'ha5, 2'b10, FLASH_IDLE);
        add_step(1'b0, FLASH_ADDR, '0, word_t'(FLASH_VALUE), 8'ha5, 2'b10, FLASH_IDLE);
    endtask

    // One four-phase access with its ack timing checked
    task automatic do_access(input step_t step, output word_t read_word);
        int edges;
        @(negedge vdp_clk);
        if (host_ack) begin
            stop_run("ack was still high when a new request was about to start");
        end
        host_we = step.we;
        host_address = step.address;
        host_write_data = step.write_data;
        host_req = 1'b1;
        edges = 0;
        do begin
            @(negedge vdp_clk);
            edges++;
        end while (!host_ack);
        if (edges != 2) begin
            stop_run($sformatf("ack rose %0d cycles after the request, not 2", edges));
        end
        read_word = host_read_data;
        host_req = 1'b0;
        @(negedge vdp_clk);
        if (host_ack) begin
            stop_run("ack did not fall on the edge after the request was dropped");
        end
    endtask

    initial begin
        word_t read_word;
        void'($urandom(32'h7db1_6295));
        vdp_reset = 1'b1;
        host_req = 1'b0;
        host_we = 1'b0;
        host_address = '0;
        host_write_data = '0;
        pad_data = PAD_VALUE;
        flash_out = FLASH_VALUE;
        build_table();
        if (num_built != NUM_STEPS) begin
            stop_run("stimulus table length does not match NUM_STEPS");
        end
        repeat (2) @(posedge vdp_clk);
        @(negedge vdp_clk);
        vdp_reset = 1'b0;
        @(negedge vdp_clk);
        check_led("led", led, '0);
        check_word("pad_latch/pad_clk", word_t'({pad_clk, pad_latch}), '0);
        check_flash("flash pins", flash_pins_t'({1'b0, flash_csn, flash_clk, flash_in_en,
            flash_in}), FLASH_IDLE);
        if (host_ack !== 1'b0) begin
            stop_run("ack was not low after reset");
        end
        for (int i = 0; i < NUM_STEPS; i++) begin
            do_access(steps[i], read_word);
            if (!steps[i].we) begin
                check_word("host_read_data", read_word, steps[i].exp_read);
            end
            check_led("led", led, steps[i].exp_led);
            check_word("pad_latch/pad_clk", word_t'({pad_clk, pad_latch}),
                word_t'(steps[i].exp_pad));
            check_flash("flash pins", flash_pins_t'({1'b0, flash_csn, flash_clk,
                flash_in_en, flash_in}), steps[i].exp_flash);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_mmio_top.f ====
+incdir+include
hw/soc_pkg.sv
hw/mmio_if.sv
hw/mmio_bus.sv
hw/io_ports.sv
hw/dsp_multiplier.sv
hw/flash_ctrl.sv
hw/soc_mmio_top.sv
testbench/soc_mmio_properties.sv
testbench/soc_mmio_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP ?= soc_mmio_tb
RTL_TOP ?= soc_mmio_top
FILELIST ?= soc_mmio_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_PATTERN ?= ^\*\* PASS \*\*$$
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard hw/*.sv testbench/*.sv include/*.svh)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q '$(PASS_PATTERN)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
